// ==== blob.f ====
hdl/blob_pkg.sv
hdl/blob_ctrl.sv
hdl/blob_labeler.sv
hdl/blob_area_table.sv
hdl/blob_stats.sv
hdl/blob_top.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_blob.sv

// ==== hdl/blob_area_table.sv ====
`default_nettype none

module blob_area_table import blob_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  blob_phase_t         i_phase,
    input  wire                 i_lbl_valid,
    input  wire  [LABEL_W-1:0]  i_lbl,
    input  wire  [LABEL_W-1:0]  i_idx,
    input  wire  [LABEL_W-1:0]  i_root_of_idx,
    output logic [AREA_W-1:0]   o_area_of_idx
);

    logic [AREA_W-1:0] area [NUM_LABELS];
    logic [AREA_W:0]   fold_sum;
    logic              fold_move;

    assign fold_move = (i_phase == PH_FOLD) && (i_root_of_idx != i_idx);
    assign fold_sum  = {1'b0, area[i_root_of_idx]} + {1'b0, area[i_idx]};

    assign o_area_of_idx = area[i_idx];

    always_ff @(posedge i_clk) begin
        case (i_phase)
            PH_IDLE: begin
                for (int i = 0; i < NUM_LABELS; i++) begin
                    area[i] <= '0;
                end
            end
            PH_STREAM: begin
                if (i_lbl_valid) begin
                    area[i_lbl] <= area[i_lbl] + 1'b1;
                end
            end
            PH_FOLD: begin
                // root is always below idx, so it is folded later
                if (fold_move) begin
                    area[i_root_of_idx] <= fold_sum[AREA_W-1:0];
                    area[i_idx]         <= '0;
                end
            end
            default: ;
        endcase
    end

    a_inc_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_phase == PH_STREAM && i_lbl_valid) |-> (area[i_lbl] != '1));

    a_fold_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        fold_move |-> !fold_sum[AREA_W]);

endmodule

`default_nettype wire

// ==== hdl/blob_ctrl.sv ====
`default_nettype none

module blob_ctrl import blob_pkg::*; (
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_req,
    input  wire                i_pix_valid,
    output logic               o_ack,
    output blob_phase_t        o_phase,
    output logic [LABEL_W-1:0] o_idx,
    output logic               o_last_pix
);

    blob_phase_t        phase;
    logic [LABEL_W-1:0] idx;
    logic [PIX_W-1:0]   pix_cnt;
    logic               ack;
    logic               last_pix;

    assign last_pix = (phase == PH_STREAM) && i_pix_valid
                      && (pix_cnt == PIX_W'(NUM_PIX - 1));

    assign o_ack      = ack;
    assign o_phase    = phase;
    assign o_idx      = idx;
    assign o_last_pix = last_pix;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            phase   <= PH_IDLE;
            idx     <= '1;
            pix_cnt <= '0;
            ack     <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    pix_cnt <= '0;
                    idx     <= '1;      // fold starts from the top label
                    if (i_req) begin
                        phase <= PH_STREAM;
                    end
                end
                PH_STREAM: begin
                    if (i_pix_valid) begin
                        pix_cnt <= pix_cnt + 1'b1;
                        if (last_pix) begin
                            phase <= PH_FOLD;
                        end
                    end
                end
                PH_FOLD: begin
                    if (idx == '0) begin
                        phase <= PH_MAX;    // idx stays at 0 for the upward scan
                    end else begin
                        idx <= idx - 1'b1;
                    end
                end
                PH_MAX: begin
                    idx <= idx + 1'b1;      // wraps back to 0
                    if (idx == '1) begin
                        phase <= PH_COUNT;
                    end
                end
                PH_COUNT: begin
                    idx <= idx + 1'b1;
                    if (idx == '1) begin
                        phase <= PH_DONE;
                    end
                end
                PH_DONE: begin
                    if (!i_req) begin
                        phase <= PH_IDLE;
                        ack   <= 1'b0;
                    end else begin
                        ack <= 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // a new request must wait for the previous ack to drop
    a_req_after_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_req) |-> !ack);

    a_phase_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        phase inside {PH_IDLE, PH_STREAM, PH_FOLD, PH_MAX, PH_COUNT, PH_DONE});

endmodule

`default_nettype wire

// ==== hdl/blob_labeler.sv ====
`default_nettype none

module blob_labeler import blob_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  blob_phase_t         i_phase,
    input  wire                 i_pix_valid,
    input  wire                 i_pix,
    input  wire  [LABEL_W-1:0]  i_idx,
    output logic                o_lbl_valid,
    output logic [LABEL_W-1:0]  o_lbl,
    output logic [LABEL_W-1:0]  o_root_of_idx,
    output logic                o_overflow
);

    logic [LABEL_W-1:0] tbl [NUM_LABELS];   // label -> final root
    logic [LABEL_W-1:0] lbuf [IMG_COL];     // labels of the last IMG_COL pixels
    logic [COL_W-1:0]   col;
    logic               first_row;
    logic [LABEL_W-1:0] next_free;
    logic               overflow;

    logic               accept;
    logic [LABEL_W-1:0] left_root;
    logic [LABEL_W-1:0] up_root;
    logic [LABEL_W-1:0] small_root;
    logic [LABEL_W-1:0] big_root;
    logic [LABEL_W-1:0] cur_lbl;
    logic               do_merge;
    logic               do_alloc;
    logic               do_ovf;

    assign accept = (i_phase == PH_STREAM) && i_pix_valid;

    // stored labels may be stale, so look them up again
    assign left_root = (col != '0) ? tbl[lbuf[0]] : '0;
    assign up_root   = first_row ? '0 : tbl[lbuf[IMG_COL-1]];

    assign small_root = (left_root < up_root) ? left_root : up_root;
    assign big_root   = (left_root < up_root) ? up_root : left_root;

    always_comb begin
        cur_lbl  = '0;
        do_merge = 1'b0;
        do_alloc = 1'b0;
        do_ovf   = 1'b0;
        if (i_pix) begin
            if (left_root != '0 && up_root != '0) begin
                cur_lbl  = small_root;
                do_merge = (left_root != up_root);
            end else if (left_root != '0) begin
                cur_lbl = left_root;
            end else if (up_root != '0) begin
                cur_lbl = up_root;
            end else if (next_free != '0) begin
                cur_lbl  = next_free;   // entry already holds itself
                do_alloc = 1'b1;
            end else begin
                do_ovf = 1'b1;          // out of labels, pixel dropped
            end
        end
    end

    assign o_lbl_valid   = accept && (cur_lbl != '0);
    assign o_lbl         = cur_lbl;
    assign o_root_of_idx = tbl[i_idx];
    assign o_overflow    = overflow;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            col       <= '0;
            first_row <= 1'b1;
            next_free <= LABEL_W'(1);
            overflow  <= 1'b0;
            for (int i = 0; i < NUM_LABELS; i++) begin
                tbl[i] <= LABEL_W'(i);
            end
        end else if (i_phase == PH_IDLE) begin
            col       <= '0;
            first_row <= 1'b1;
            next_free <= LABEL_W'(1);
            overflow  <= 1'b0;
            for (int i = 0; i < NUM_LABELS; i++) begin
                tbl[i] <= LABEL_W'(i);
            end
        end else if (accept) begin
            if (col == COL_W'(IMG_COL - 1)) begin
                col       <= '0;
                first_row <= 1'b0;
            end else begin
                col <= col + 1'b1;
            end
            if (do_alloc) begin
                next_free <= next_free + 1'b1;  // 63 wraps to 0 = exhausted
            end
            if (do_ovf) begin
                overflow <= 1'b1;
            end
            // keep the table flat in one step
            if (do_merge) begin
                for (int i = 0; i < NUM_LABELS; i++) begin
                    if (tbl[i] == big_root) begin
                        tbl[i] <= small_root;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            lbuf[0] <= cur_lbl;
            for (int i = 1; i < IMG_COL; i++) begin
                lbuf[i] <= lbuf[i-1];
            end
        end
    end

    // every entry points down to a root that points to itself
    for (genvar g = 0; g < NUM_LABELS; g++) begin : g_flat
        a_flat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            (tbl[g] <= LABEL_W'(g)) && (tbl[tbl[g]] == tbl[g]));
    end

endmodule

`default_nettype wire

// ==== hdl/blob_pkg.sv ====
`default_nettype none

package blob_pkg;

    // image geometry
    localparam int IMG_COL = 16;
    localparam int IMG_ROW = 12;
    localparam int NUM_PIX = IMG_COL * IMG_ROW;
    localparam int COL_W   = 4;
    localparam int PIX_W   = 8;     // pixel counter, holds NUM_PIX - 1

    // label 0 is background
    localparam int NUM_LABELS = 64;
    localparam int LABEL_W    = 6;

    localparam int AREA_W  = 8;     // a full frame fits
    localparam int COUNT_W = 7;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_STREAM,
        PH_FOLD,
        PH_MAX,
        PH_COUNT,
        PH_DONE
    } blob_phase_t;

endpackage

`default_nettype wire

// ==== hdl/blob_stats.sv ====
`default_nettype none

module blob_stats import blob_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  blob_phase_t         i_phase,
    input  wire  [AREA_W-1:0]   i_area_of_idx,
    output logic [AREA_W-1:0]   o_max_area,
    output logic [COUNT_W-1:0]  o_count
);

    logic [AREA_W-1:0]  max_area;
    logic [COUNT_W-1:0] count;
    logic [AREA_W-1:0]  thresh;

    assign thresh = max_area >> 3;   // one eighth, rounded down

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            max_area <= '0;
            count    <= '0;
        end else begin
            case (i_phase)
                PH_IDLE: begin
                    max_area <= '0;
                    count    <= '0;
                end
                PH_MAX: begin
                    if (i_area_of_idx > max_area) begin
                        max_area <= i_area_of_idx;
                    end
                end
                PH_COUNT: begin
                    // non-root entries are zero after the fold
                    if (i_area_of_idx > thresh) begin
                        count <= count + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    assign o_max_area = max_area;
    assign o_count    = count;

endmodule

`default_nettype wire

// ==== hdl/blob_top.sv ====
`default_nettype none

module blob_top import blob_pkg::*; (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    input  wire                 i_req,
    input  wire                 i_pix_valid,
    input  wire                 i_pix,
    output logic                o_ack,
    output logic [COUNT_W-1:0]  o_count,
    output logic [AREA_W-1:0]   o_max_area,
    output logic                o_overflow
);

    blob_phase_t        phase;
    logic [LABEL_W-1:0] idx;
    logic               lbl_valid;
    logic [LABEL_W-1:0] lbl;
    logic [LABEL_W-1:0] root_of_idx;
    logic [AREA_W-1:0]  area_of_idx;

    blob_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_pix_valid (i_pix_valid),
        .o_ack       (o_ack),
        .o_phase     (phase),
        .o_idx       (idx),
        .o_last_pix  ()
    );

    blob_labeler u_labeler (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_phase       (phase),
        .i_pix_valid   (i_pix_valid),
        .i_pix         (i_pix),
        .i_idx         (idx),
        .o_lbl_valid   (lbl_valid),
        .o_lbl         (lbl),
        .o_root_of_idx (root_of_idx),
        .o_overflow    (o_overflow)
    );

    blob_area_table u_area (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_phase       (phase),
        .i_lbl_valid   (lbl_valid),
        .i_lbl         (lbl),
        .i_idx         (idx),
        .i_root_of_idx (root_of_idx),
        .o_area_of_idx (area_of_idx)
    );

    blob_stats u_stats (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_phase       (phase),
        .i_area_of_idx (area_of_idx),
        .o_max_area    (o_max_area),
        .o_count       (o_count)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the blob counter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_blob -f blob.f -o tb_blob || exit 1

out=$(./obj_dir/tb_blob)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED" && exit 0 || exit 1

// ==== tb/tb_blob.sv ====
`default_nettype none

module tb_blob import blob_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED = 32'h9c80_8aa7;
    localparam int NUM_FRAMES = 20;
    localparam int MAX_GAPS   = NUM_PIX;    // at most one idle cycle per pixel
    localparam int TIMEOUT    = NUM_FRAMES * (NUM_PIX + 3 * NUM_LABELS + MAX_GAPS + 10) + 20;

    // image kinds, the first five frames run them in this order
    localparam int K_ZERO    = 0;
    localparam int K_ONE     = 1;
    localparam int K_CHECKER = 2;
    localparam int K_U       = 3;
    localparam int K_STAIR   = 4;
    localparam int K_RAND    = 5;

    logic               clk;
    logic               rst_n;
    logic               req;
    logic               pix_valid;
    logic               pix;
    logic               ack;
    logic [COUNT_W-1:0] count;
    logic [AREA_W-1:0]  max_area;
    logic               overflow;
    logic [COUNT_W-1:0] exp_count;
    logic [AREA_W-1:0]  exp_max;
    logic               exp_ovf;
    logic [31:0]        err_cnt;
    logic [31:0]        frames;

    bit          img [NUM_PIX];
    logic [31:0] lfsr;
    int          cyc = 0;
    int          tb_err;
    int          total;
    int          kind;
    int          ref_max;
    int          ref_count;
    bit          ref_ovf;

    tb_clock u_clock (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    blob_top u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_req       (req),
        .i_pix_valid (pix_valid),
        .i_pix       (pix),
        .o_ack       (ack),
        .o_count     (count),
        .o_max_area  (max_area),
        .o_overflow  (overflow)
    );

    tb_checker u_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_req       (req),
        .i_pix_valid (pix_valid),
        .i_ack       (ack),
        .i_count     (count),
        .i_max_area  (max_area),
        .i_overflow  (overflow),
        .i_exp_count (exp_count),
        .i_exp_max   (exp_max),
        .i_exp_ovf   (exp_ovf),
        .o_err_cnt   (err_cnt),
        .o_frames    (frames)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic make_image(input int k, input int density);
        int r;
        int c;
        int v;
        for (int p = 0; p < NUM_PIX; p++) begin
            r = p / IMG_COL;
            c = p % IMG_COL;
            case (k)
                K_ZERO:    img[p] = 1'b0;
                K_ONE:     img[p] = 1'b1;
                K_CHECKER: img[p] = ((r + c) % 2) == 0;
                // arms start apart, the thick bottom bar joins them
                K_U:       img[p] = (r < 10 && ((c >= 1 && c <= 3) || (c >= 11 && c <= 13)))
                                    || (r >= 10 && c >= 1 && c <= 13);
                K_STAIR:   img[p] = (c == 14 - r) || (c == 15 - r);
                default: begin
                    take_bits(3, v);
                    img[p] = v < density;   // density in eighths
                end
            endcase
        end
    endtask

    // flood fill over the stored image, 4-connected
    function automatic void ref_model(output int max_r, output int count_r, output bit ovf_r);
        int lab [NUM_PIX];
        int stack [NUM_PIX];
        int areas [NUM_PIX];
        int sp;
        int nb;
        int q;
        int r;
        int c;
        int nr;
        int nc;
        int n;
        int n_new;
        nb      = 0;
        n_new   = 0;
        max_r   = 0;
        count_r = 0;
        for (int p = 0; p < NUM_PIX; p++) begin
            lab[p] = 0;
        end
        for (int p = 0; p < NUM_PIX; p++) begin
            if (img[p] && lab[p] == 0) begin
                nb++;
                lab[p]      = nb;
                stack[0]    = p;
                sp          = 1;
                areas[nb-1] = 0;
                while (sp > 0) begin
                    sp--;
                    q = stack[sp];
                    areas[nb-1]++;
                    r = q / IMG_COL;
                    c = q % IMG_COL;
                    for (int d = 0; d < 4; d++) begin
                        nr = r + ((d == 0) ? -1 : (d == 1) ? 1 : 0);
                        nc = c + ((d == 2) ? -1 : (d == 3) ? 1 : 0);
                        if (nr >= 0 && nr < IMG_ROW && nc >= 0 && nc < IMG_COL) begin
                            n = nr * IMG_COL + nc;
                            if (img[n] && lab[n] == 0) begin
                                lab[n]    = nb;
                                stack[sp] = n;
                                sp++;
                            end
                        end
                    end
                end
                if (areas[nb-1] > max_r) begin
                    max_r = areas[nb-1];
                end
            end
        end
        for (int b = 0; b < nb; b++) begin
            if (areas[b] > (max_r >> 3)) begin
                count_r++;
            end
        end
        // a pixel with no set neighbour left or above takes a fresh label
        for (int p = 0; p < NUM_PIX; p++) begin
            r = p / IMG_COL;
            c = p % IMG_COL;
            if (img[p] && (c == 0 || !img[p-1]) && (r == 0 || !img[p-IMG_COL])) begin
                n_new++;
            end
        end
        ovf_r = n_new > NUM_LABELS - 1;
    endfunction

    task automatic send_frame(input bit gaps);
        int g;
        @(posedge clk);
        req <= 1'b1;
        @(posedge clk);             // DUT enters the stream phase here
        for (int p = 0; p < NUM_PIX; p++) begin
            if (gaps) begin
                take_bits(2, g);
                if (g == 3) begin
                    pix_valid <= 1'b0;
                    pix       <= 1'b0;
                    @(posedge clk);
                end
            end
            pix_valid <= 1'b1;
            pix       <= img[p];
            @(posedge clk);
        end
        pix_valid <= 1'b0;
        pix       <= 1'b0;
        while (ack !== 1'b1) @(posedge clk);
        req <= 1'b0;
        while (ack !== 1'b0) @(posedge clk);
    endtask

    initial begin
        req       = 1'b0;
        pix_valid = 1'b0;
        pix       = 1'b0;
        exp_count = '0;
        exp_max   = '0;
        exp_ovf   = 1'b0;
        lfsr      = SEED;
        tb_err    = 0;
        while (rst_n !== 1'b1) @(posedge clk);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            kind = (f < K_RAND) ? f : K_RAND;
            make_image(kind, 2 + f % 5);
            ref_model(ref_max, ref_count, ref_ovf);
            exp_max   = AREA_W'(ref_max);
            exp_count = COUNT_W'(ref_count);
            exp_ovf   = ref_ovf;
            send_frame(kind == K_RAND);
        end
        repeat (2) @(posedge clk);
        if (frames != NUM_FRAMES) begin
            $display("only %0d of %0d frames returned a result", frames, NUM_FRAMES);
            tb_err++;
        end
        total = tb_err + int'(err_cnt);
        $display("%0d errors over %0d frames", total, frames);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cyc++;
        if (cyc >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
`default_nettype none

module tb_checker import blob_pkg::*; (
    input  wire                i_clk,
    input  wire                i_rst_n,
    input  wire                i_req,
    input  wire                i_pix_valid,
    input  wire                i_ack,
    input  wire [COUNT_W-1:0]  i_count,
    input  wire [AREA_W-1:0]   i_max_area,
    input  wire                i_overflow,
    input  wire [COUNT_W-1:0]  i_exp_count,
    input  wire [AREA_W-1:0]   i_exp_max,
    input  wire                i_exp_ovf,
    output logic [31:0]        o_err_cnt,
    output logic [31:0]        o_frames
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACK_DELAY = 3 * NUM_LABELS + 1;   // last pixel to ack

    int   err_cnt      = 0;
    int   frames       = 0;
    int   cyc          = 0;
    int   pix_cnt      = 0;
    int   last_cyc     = 0;
    int   req_fall_cyc = 0;
    logic ack_q        = 1'b0;
    logic req_q        = 1'b0;
    logic rst_seen     = 1'b0;

    assign o_err_cnt = err_cnt;
    assign o_frames  = frames;

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%h, expected 0x%h (frame %0d)", name, got, exp, frames);
        err_cnt++;
    endtask

    task automatic check_result();
        frames++;
        if (i_overflow !== i_exp_ovf) begin
            report_mismatch("o_overflow", 32'(i_overflow), 32'(i_exp_ovf));
        end
        if (!i_exp_ovf) begin   // results are only defined without overflow
            if (i_count !== i_exp_count) begin
                report_mismatch("o_count", 32'(i_count), 32'(i_exp_count));
            end
            if (i_max_area !== i_exp_max) begin
                report_mismatch("o_max_area", 32'(i_max_area), 32'(i_exp_max));
            end
        end
        if (pix_cnt != NUM_PIX) begin
            $display("o_ack rose after only %0d of %0d pixels", pix_cnt, NUM_PIX);
            err_cnt++;
        end else if (cyc - 1 - last_cyc != ACK_DELAY) begin
            $display("o_ack rose %0d cycles after the last pixel instead of %0d",
                     cyc - 1 - last_cyc, ACK_DELAY);
            err_cnt++;
        end
    endtask

    // values seen here are the ones the DUT sampled at this edge
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            cyc++;
            if (!rst_seen) begin
                rst_seen = 1'b1;
                if (i_ack !== 1'b0) begin
                    $display("o_ack is not low after reset");
                    err_cnt++;
                end
            end
            if (i_req && !req_q) begin
                pix_cnt = 0;
            end
            if (!i_req && req_q) begin
                req_fall_cyc = cyc;
            end
            if (i_req && i_pix_valid) begin
                pix_cnt++;
                if (pix_cnt == NUM_PIX) begin
                    last_cyc = cyc;
                end
            end
            if (i_ack && !ack_q) begin
                check_result();
            end
            if (!i_ack && ack_q && (cyc - req_fall_cyc != 1)) begin
                $display("o_ack fell %0d cycles after i_req fell", cyc - req_fall_cyc);
                err_cnt++;
            end
            ack_q = i_ack;
            req_q = i_req;
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD     = 100;
    localparam int RST_CYCLES = 5;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
